/* hdl/cart_pkg.sv */
package cart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int snes_addr_w = 24;  // A-bus address
  localparam int snes_pa_w   = 8;   // B-bus peripheral address
  localparam int snes_data_w = 8;   // Data bus, both buses

  ////////////////////////////////////////////////////////////////////////////
  // Access kinds and decoded regions
  ////////////////////////////////////////////////////////////////////////////

  // Which strobe started the access
  typedef enum logic [1:0] {
    ACC_READ,     // RD on the A-bus
    ACC_WRITE,    // WR on the A-bus
    ACC_PA_READ   // PARD on the B-bus
  } access_kind_e;

  // Target of an access after decode
  typedef enum logic [2:0] {
    REG_NONE,     // Open bus
    REG_ROM,      // Folded LoROM space
    REG_VECT,     // xxFFE0-xxFFFF reads, vectors from Cx4 window
    REG_CX4,      // Cx4 MMIO 6000-7FFF
    REG_MSU,      // MSU-1 registers 2000-2007
    REG_CMD_WR,   // Command buffer, A-bus write side
    REG_CMD_RD,   // Command buffer, B-bus read side
    REG_213F      // PPU2 status stand-in
  } region_e;

endpackage

/* hdl/snes_access_if.sv */
`timescale 1ns/10ps

// One SNES access moving between pipeline stages in the CLK domain.
// No handshake, fields only mean something while stb is high
interface snes_access_if;

  logic                                 stb;       // One-cycle access pulse
  cart_pkg::access_kind_e               kind;      // Read, write or B-bus read
  logic [cart_pkg::snes_addr_w-1:0]     addr;      // A-bus address
  logic [cart_pkg::snes_pa_w-1:0]       pa;        // B-bus address
  logic [cart_pkg::snes_data_w-1:0]     wdata;     // Write data
  logic [cart_pkg::snes_addr_w-1:0]     rom_addr;  // Masked ROM address
  cart_pkg::region_e                    region;    // Decoded target

  // Producing stage
  modport source (
    output stb,
    output kind,
    output addr,
    output pa,
    output wdata,
    output rom_addr,
    output region
  );

  // Consuming stage
  modport sink (
    input stb,
    input kind,
    input addr,
    input pa,
    input wdata,
    input rom_addr,
    input region
  );

endinterface

/* hdl/snes_bus_sampler.sv */
`timescale 1ns/10ps

module snes_bus_sampler #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                                 CLK,
  input  logic                                 rst_n,
  input  logic [cart_pkg::snes_addr_w-1:0]     snes_addr,
  input  logic [cart_pkg::snes_pa_w-1:0]       snes_pa,
  input  logic [cart_pkg::snes_data_w-1:0]     snes_data,
  input  logic                                 snes_romsel_n,
  input  logic                                 snes_rd_n,
  input  logic                                 snes_wr_n,
  input  logic                                 snes_pard_n,
  snes_access_if.source                        acc
);

  ////////////////////////////////////////////////////////////////////////////
  // Strobe synchronizers
  ////////////////////////////////////////////////////////////////////////////

  // Bit 2 WR, bit 1 RD, bit 0 PARD; entry 0 is the newest sample
  logic [SYNC_STAGES:0][2:0] strb_q;
  logic [2:0]                fall;   // Falling edge per strobe

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      strb_q <= '1;                                  // Strobes idle high
    end else begin
      strb_q <= {strb_q[SYNC_STAGES-1:0], {snes_wr_n, snes_rd_n, snes_pard_n}};
    end
  end

  // Extra stage past the synchronizer acts as the previous value
  assign fall = strb_q[SYNC_STAGES] & ~strb_q[SYNC_STAGES-1];

  ////////////////////////////////////////////////////////////////////////////
  // Access capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      acc.stb <= 1'b0;
    end else begin
      acc.stb <= |fall;                              // At most one pulse per edge
    end
  end

  // Bus fields held stable by the SNES, grab them with the pulse
  always_ff @(posedge CLK) begin
    if (|fall) begin
      acc.addr  <= snes_addr;
      acc.pa    <= snes_pa;
      acc.wdata <= snes_data;
      // ROMSEL rides in region until the address map decodes it
      acc.region <= snes_romsel_n ? cart_pkg::REG_NONE : cart_pkg::REG_ROM;
      if (fall[2])      acc.kind <= cart_pkg::ACC_WRITE;    // Write wins
      else if (fall[1]) acc.kind <= cart_pkg::ACC_READ;
      else              acc.kind <= cart_pkg::ACC_PA_READ;
    end
  end

  assign acc.rom_addr = '0;   // Filled in by the address map

  // Back-to-back pulses would mean two strobes fell on adjacent edges
  a_stb_single: assert property (@(posedge CLK) disable iff (!rst_n)
    acc.stb |=> !acc.stb);

  // PARD must be idle while a write is sampled
  a_wr_not_bbus: assert property (@(posedge CLK) disable iff (!rst_n)
    acc.stb && acc.kind == cart_pkg::ACC_WRITE |-> $past(strb_q[SYNC_STAGES-1][0]));

endmodule

/* hdl/cart_address_map.sv */
`timescale 1ns/10ps

module cart_address_map (
  input  logic                               CLK,
  input  logic                               rst_n,
  snes_access_if.sink                        smp,
  input  logic [cart_pkg::snes_addr_w-1:0]   rom_mask,
  input  logic                               use_msu1,
  snes_access_if.source                      dec
);

  logic                               romsel_act;  // ROMSEL low at sample time
  logic [cart_pkg::snes_addr_w-1:0]   rom_addr_c;  // Folded and masked
  cart_pkg::region_e                  region_c;

  assign romsel_act = (smp.region == cart_pkg::REG_ROM);

  ////////////////////////////////////////////////////////////////////////////
  // Cx4 LoROM fold
  ////////////////////////////////////////////////////////////////////////////

  // Drop A15, keep bank bits 22:16, upper bank bit ignored
  assign rom_addr_c = {2'b00, smp.addr[22:16], smp.addr[14:0]} & rom_mask;

  ////////////////////////////////////////////////////////////////////////////
  // Region decode, highest priority first
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    region_c = cart_pkg::REG_NONE;
    if (smp.kind == cart_pkg::ACC_PA_READ) begin
      // B-bus only reaches the command buffer or 213F
      if (smp.pa[7:4] == 4'hf) begin
        region_c = cart_pkg::REG_CMD_RD;
      end else if (smp.pa == 8'h3f) begin
        region_c = cart_pkg::REG_213F;
      end
    end else if (smp.kind == cart_pkg::ACC_WRITE && smp.addr[23:4] == 20'hccccc) begin
      region_c = cart_pkg::REG_CMD_WR;                  // CCCCC0-CCCCCF
    end else if (use_msu1 && !smp.addr[22] && smp.addr[15:3] == 13'h0400) begin
      region_c = cart_pkg::REG_MSU;                     // 2000-2007
    end else if (!smp.addr[22] && smp.addr[15:13] == 3'b011) begin
      region_c = cart_pkg::REG_CX4;                     // 6000-7FFF
    end else if (romsel_act && smp.kind == cart_pkg::ACC_READ && (&smp.addr[15:5])) begin
      region_c = cart_pkg::REG_VECT;                    // Vectors
    end else if (romsel_act) begin
      region_c = cart_pkg::REG_ROM;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      dec.stb <= 1'b0;
    end else begin
      dec.stb <= smp.stb;
    end
  end

  always_ff @(posedge CLK) begin
    if (smp.stb) begin
      dec.kind     <= smp.kind;
      dec.addr     <= smp.addr;
      dec.pa       <= smp.pa;
      dec.wdata    <= smp.wdata;
      dec.rom_addr <= rom_addr_c;
      dec.region   <= region_c;
    end
  end

  // ROM space only reachable with ROMSEL active one stage back
  a_rom_needs_romsel: assert property (@(posedge CLK) disable iff (!rst_n)
    dec.stb && (dec.region inside {cart_pkg::REG_ROM, cart_pkg::REG_VECT})
    |-> $past(smp.region == cart_pkg::REG_ROM));

endmodule

/* hdl/cart_access_router.sv */
`timescale 1ns/10ps

module cart_access_router (
  input  logic                               CLK,
  input  logic                               rst_n,
  snes_access_if.sink                        dec,
  input  logic [cart_pkg::snes_data_w-1:0]   rom_data,
  input  logic [cart_pkg::snes_data_w-1:0]   r213f_value,
  output logic                               rom_rd,
  output logic [cart_pkg::snes_addr_w-1:0]   rom_addr,
  output logic [cart_pkg::snes_data_w-1:0]   rd_data,
  output logic                               rd_valid
);

  localparam int DW = cart_pkg::snes_data_w;

  logic [DW-1:0]      cx4_mem [32];   // Cx4 MMIO stand-in
  logic [DW-1:0]      msu_mem [8];    // MSU-1 registers
  logic [DW-1:0]      cmd_mem [16];   // Command buffer
  logic               is_rd;
  logic               is_wr;
  logic [DW-1:0]      loc_data;       // Local read data at decode time
  logic [2:0]         vld_q;          // Read delay line
  cart_pkg::region_e  region_q [2];
  logic [DW-1:0]      data_q [2];

  assign is_rd = dec.stb && dec.kind != cart_pkg::ACC_WRITE;
  assign is_wr = dec.stb && dec.kind == cart_pkg::ACC_WRITE;

  ////////////////////////////////////////////////////////////////////////////
  // Register windows, writes land one cycle after the strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) cx4_mem[i] <= '0;
      for (int i = 0; i < 8; i++)  msu_mem[i] <= '0;
      for (int i = 0; i < 16; i++) cmd_mem[i] <= '0;
    end else if (is_wr) begin
      case (dec.region)
        cart_pkg::REG_CX4:    cx4_mem[dec.addr[4:0]] <= dec.wdata;
        cart_pkg::REG_MSU:    msu_mem[dec.addr[2:0]] <= dec.wdata;
        cart_pkg::REG_CMD_WR: cmd_mem[dec.addr[3:0]] <= dec.wdata;
        default: ;                                    // ROM writes dropped
      endcase
    end
  end

  // Read the window now so later writes cannot slip into this read
  always_comb begin
    case (dec.region)
      cart_pkg::REG_CX4,
      cart_pkg::REG_VECT:   loc_data = cx4_mem[dec.addr[4:0]];  // Vectors from Cx4
      cart_pkg::REG_MSU:    loc_data = msu_mem[dec.addr[2:0]];
      cart_pkg::REG_CMD_RD: loc_data = cmd_mem[dec.pa[3:0]];
      cart_pkg::REG_213F:   loc_data = r213f_value;
      default:              loc_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // ROM request
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rom_rd <= 1'b0;
    end else begin
      rom_rd <= is_rd && dec.region == cart_pkg::REG_ROM;
    end
  end

  always_ff @(posedge CLK) begin
    if (dec.stb) rom_addr <= dec.rom_addr;   // Held until the next access
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read delay line and data return
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[1:0], is_rd};
    end
  end

  always_ff @(posedge CLK) begin
    region_q[0] <= dec.region;
    region_q[1] <= region_q[0];
    data_q[0]   <= loc_data;
    data_q[1]   <= data_q[0];
  end

  // ROM data arrives in the slot of vld_q[1]
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (vld_q[1]) begin
      case (region_q[1])
        cart_pkg::REG_ROM:  rd_data <= rom_data;
        cart_pkg::REG_NONE: rd_data <= rd_data;     // Open bus
        default:            rd_data <= data_q[1];
      endcase
    end
  end

  assign rd_valid = vld_q[2];   // Always three cycles after dec.stb

  // Two ROM reads can never be adjacent given the sampler spacing
  a_rom_rd_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
    rom_rd |=> !rom_rd);

  a_no_valid_on_wr: assert property (@(posedge CLK) disable iff (!rst_n)
    is_wr |-> ##3 !rd_valid);

endmodule

/* hdl/cart_frontend_top.sv */
`timescale 1ns/10ps

module cart_frontend_top #(
  parameter int SYNC_STAGES = 2   // Synchronizer depth for SNES strobes
) (
  input  logic                               CLK,
  input  logic                               rst_n,
  // SNES side, asynchronous
  input  logic [cart_pkg::snes_addr_w-1:0]   snes_addr,
  input  logic [cart_pkg::snes_pa_w-1:0]     snes_pa,
  input  logic [cart_pkg::snes_data_w-1:0]   snes_data,
  input  logic                               snes_romsel_n,
  input  logic                               snes_rd_n,
  input  logic                               snes_wr_n,
  input  logic                               snes_pard_n,
  // Static levels from the MCU
  input  logic [cart_pkg::snes_addr_w-1:0]   rom_mask,
  input  logic                               use_msu1,
  input  logic [cart_pkg::snes_data_w-1:0]   r213f_value,
  // Synchronous ROM port
  output logic                               rom_rd,
  output logic [cart_pkg::snes_addr_w-1:0]   rom_addr,
  input  logic [cart_pkg::snes_data_w-1:0]   rom_data,
  // Read return
  output logic [cart_pkg::snes_data_w-1:0]   rd_data,
  output logic                               rd_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////////////////////////////////////////

  snes_access_if smp_if ();   // Sampler to address map
  snes_access_if dec_if ();   // Address map to router

  snes_bus_sampler #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_sampler (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .snes_addr     (snes_addr),
    .snes_pa       (snes_pa),
    .snes_data     (snes_data),
    .snes_romsel_n (snes_romsel_n),
    .snes_rd_n     (snes_rd_n),
    .snes_wr_n     (snes_wr_n),
    .snes_pard_n   (snes_pard_n),
    .acc           (smp_if.source)
  );

  cart_address_map u_addr_map (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .smp      (smp_if.sink),
    .rom_mask (rom_mask),
    .use_msu1 (use_msu1),
    .dec      (dec_if.source)
  );

  cart_access_router u_router (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .dec         (dec_if.sink),
    .rom_data    (rom_data),
    .r213f_value (r213f_value),
    .rom_rd      (rom_rd),
    .rom_addr    (rom_addr),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid)
  );

endmodule

/* bench/tb_cart_frontend.sv */
`timescale 1ns/10ps

module tb_cart_frontend;

  localparam int sync_stages = 2;
  localparam int drain_limit = 40;   // Cycles allowed for outstanding reads

  logic        CLK;
  logic        rst_n;
  logic [23:0] snes_addr;
  logic [7:0]  snes_pa;
  logic [7:0]  snes_data;
  logic        snes_romsel_n;
  logic        snes_rd_n;
  logic        snes_wr_n;
  logic        snes_pard_n;
  logic [23:0] rom_mask;
  logic        use_msu1;
  logic [7:0]  r213f_value;
  logic        rom_rd;
  logic [23:0] rom_addr;
  logic [7:0]  rom_data;
  logic [7:0]  rd_data;
  logic        rd_valid;

  logic [7:0]  exp_q[$];        // Expected rd_data in issue order
  logic [23:0] exp_rom_q[$];    // Expected rom_addr per ROM read
  logic [7:0]  last_exp;        // Value the bus holds when nothing drives it
  logic [7:0]  exp_byte;
  logic [23:0] exp_ra;
  logic [7:0]  cx4_model [32];
  logic [7:0]  msu_model [8];
  logic [7:0]  cmd_model [16];
  logic [23:0] cx4_addrs [8];
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;

  cart_frontend_top #(.SYNC_STAGES(sync_stages)) UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Synchronous ROM answers one cycle after the request
  always @(posedge CLK) begin
    if (rom_rd) rom_data <= rom_addr[7:0] ^ rom_addr[15:8];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (rst_n && rom_rd) begin
      if (exp_rom_q.size() == 0) begin
        $display("ROM request with no ROM read outstanding at %0t", $time);
        errors++;
      end else begin
        exp_ra = exp_rom_q.pop_front();
        checks++;
        a_rom_addr: assert (rom_addr == exp_ra) else begin
          $display("MISMATCH rom_addr got 0x%06h expected 0x%06h", rom_addr, exp_ra);
          errors++;
        end
      end
    end
    if (rst_n && rd_valid) begin
      if (exp_q.size() == 0) begin
        $display("rd_valid with no read outstanding at %0t", $time);
        errors++;
      end else begin
        exp_byte = exp_q.pop_front();   // Oldest read first
        checks++;
        a_rd_data: assert (rd_data == exp_byte) else begin
          $display("MISMATCH rd_data got 0x%02h expected 0x%02h", rd_data, exp_byte);
          errors++;
        end
      end
    end
  end

  a_quiet_in_reset: assert property (@(negedge CLK)
    !rst_n |-> !rom_rd && !rd_valid && rd_data == 8'h00) else begin
    $display("ROM port or read return active during reset at %0t", $time);
    errors++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Address a cycle ahead, strobe low for 4 cycles, then 6 idle cycles
  task automatic bus_access(input cart_pkg::access_kind_e kind, input logic [23:0] addr,
                            input logic [7:0] pa, input logic [7:0] data, input logic romsel);
    @(posedge CLK);
    snes_addr     <= addr;
    snes_pa       <= pa;
    snes_data     <= data;
    snes_romsel_n <= ~romsel;
    @(posedge CLK);
    case (kind)
      cart_pkg::ACC_WRITE: snes_wr_n   <= 1'b0;
      cart_pkg::ACC_READ:  snes_rd_n   <= 1'b0;
      default:             snes_pard_n <= 1'b0;
    endcase
    repeat (4) @(posedge CLK);
    snes_wr_n     <= 1'b1;
    snes_rd_n     <= 1'b1;
    snes_pard_n   <= 1'b1;
    snes_romsel_n <= 1'b1;
    repeat (6) @(posedge CLK);
  endtask

  task automatic expect_read(input logic [7:0] value);
    exp_q.push_back(value);
    last_exp = value;   // Open bus keeps this
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || exp_rom_q.size() != 0) && n < drain_limit) begin
      @(posedge CLK);
      n++;
    end
    if (exp_q.size() != 0 || exp_rom_q.size() != 0) begin
      $display("Timeout waiting for %0d outstanding reads", exp_q.size() + exp_rom_q.size());
      errors++;
      exp_q.delete();
      exp_rom_q.delete();
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %-8s ok", name);
    end else begin
      tests_failed++;
      $display("test %-8s FAILED with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // Bank bits 22:16 land on 21:15 and A15 drops out
  function automatic logic [23:0] lorom_fold(input logic [23:0] a, input logic [23:0] mask);
    return (((a >> 1) & 24'h3f8000) | (a & 24'h007fff)) & mask;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [23:0] a;
    logic [23:0] ra;
    logic [23:0] mask;
    logic [7:0]  d;
    int          idx;
    void'($urandom(60474));
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    errors_at_start = 0;
    rst_n = 1'b0;
    snes_addr = '0;
    snes_pa = '0;
    snes_data = '0;
    snes_romsel_n = 1'b1;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    snes_pard_n = 1'b1;
    rom_mask = 24'hffffff;
    use_msu1 = 1'b0;
    r213f_value = 8'h00;
    rom_data = 8'h00;
    last_exp = 8'h00;
    for (int i = 0; i < 32; i++) cx4_model[i] = 8'h00;
    for (int i = 0; i < 8; i++) msu_model[i] = 8'h00;
    for (int i = 0; i < 16; i++) cmd_model[i] = 8'h00;

    repeat (3) @(posedge CLK);
    rst_n <= 1'b1;
    repeat (4) @(posedge CLK);
    checks++;
    a_rd_data_reset: assert (rd_data == 8'h00) else begin
      $display("MISMATCH rd_data got 0x%02h expected 0x00", rd_data);
      errors++;
    end
    finish_test("reset");

    // ROM reads under two masks
    for (int m = 0; m < 2; m++) begin
      mask = (m == 0) ? 24'h0fffff : 24'h01ffff;
      @(posedge CLK);
      rom_mask <= mask;
      for (int i = 0; i < 6; i++) begin
        a = 24'($urandom);
        a[15] = 1'b1;                  // Upper half of the bank
        if (&a[15:5]) a[5] = 1'b0;     // Keep out of the vectors
        ra = lorom_fold(a, mask);
        exp_rom_q.push_back(ra);
        expect_read(ra[7:0] ^ ra[15:8]);
        bus_access(cart_pkg::ACC_READ, a, 8'h00, 8'h00, 1'b1);
      end
      wait_drain();
    end
    finish_test("rom");

    // Cx4 window readback and then vectors
    for (int i = 0; i < 8; i++) begin
      a = 24'($urandom);
      a[22] = 1'b0;
      a[15:13] = 3'b011;               // 6000-7FFF
      d = 8'($urandom);
      cx4_addrs[i] = a;
      cx4_model[a[4:0]] = d;
      bus_access(cart_pkg::ACC_WRITE, a, 8'h00, d, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      expect_read(cx4_model[cx4_addrs[i][4:0]]);
      bus_access(cart_pkg::ACC_READ, cx4_addrs[i], 8'h00, 8'h00, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      a = 24'($urandom);
      a[15:5] = '1;                    // FFE0-FFFF
      a[4:0] = cx4_addrs[i][4:0];
      expect_read(cx4_model[a[4:0]]);  // No ROM request expected
      bus_access(cart_pkg::ACC_READ, a, 8'h00, 8'h00, 1'b1);
    end
    wait_drain();
    finish_test("cx4");

    // MSU-1 window enabled and then disabled
    @(posedge CLK);
    use_msu1 <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      a = 24'($urandom);
      a[22] = 1'b0;
      a[15:0] = 16'h2000;
      a[2:0] = 3'(i);
      d = 8'($urandom);
      msu_model[i] = d;
      bus_access(cart_pkg::ACC_WRITE, a, 8'h00, d, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      expect_read(msu_model[i]);
      bus_access(cart_pkg::ACC_READ, {8'h00, 13'h0400, 3'(i)}, 8'h00, 8'h00, 1'b0);
    end
    wait_drain();
    @(posedge CLK);
    use_msu1 <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      expect_read(last_exp);           // Open bus
      bus_access(cart_pkg::ACC_READ, {8'h00, 13'h0400, 3'(i)}, 8'h00, 8'h00, 1'b0);
    end
    wait_drain();
    finish_test("msu1");

    // Command buffer written on the A-bus and read on the B-bus
    for (int i = 0; i < 16; i++) begin
      d = 8'($urandom);
      cmd_model[i] = d;
      bus_access(cart_pkg::ACC_WRITE, {20'hccccc, 4'(i)}, 8'h00, d, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      idx = $urandom_range(15, 0);
      expect_read(cmd_model[idx]);
      bus_access(cart_pkg::ACC_PA_READ, 24'h000000, {4'hf, 4'(idx)}, 8'h00, 1'b0);
    end
    wait_drain();
    finish_test("cmdbuf");

    // 213F reads mixed with buffer reads and no drain in between
    for (int v = 0; v < 2; v++) begin
      d = 8'($urandom);
      @(posedge CLK);
      r213f_value <= d;
      for (int i = 0; i < 3; i++) begin
        expect_read(d);
        bus_access(cart_pkg::ACC_PA_READ, 24'h000000, 8'h3f, 8'h00, 1'b0);
        idx = $urandom_range(15, 0);
        expect_read(cmd_model[idx]);
        bus_access(cart_pkg::ACC_PA_READ, 24'h000000, {4'hf, 4'(idx)}, 8'h00, 1'b0);
      end
      wait_drain();
    end
    finish_test("r213f");

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tb.f */
hdl/cart_pkg.sv
hdl/snes_access_if.sv
hdl/snes_bus_sampler.sv
hdl/cart_address_map.sv
hdl/cart_access_router.sv
hdl/cart_frontend_top.sv
bench/tb_cart_frontend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cart_frontend
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
